// File: source/McbPkg.sv
/* Bus widths, CSR offsets, FIFO sizing and the packed structs
   shared by the management block */
package McbPkg;

	// ------------------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------------------
	localparam int lpUsiBusWidth  = 32;
	localparam int lpUfiDqWidth   = 16;
	localparam int lpUfiAdrsWidth = 32;
	// GPIO word halves
	localparam int lpGpioWidth    = lpUsiBusWidth / 2;
	// Top UFI address bit is the read-valid flag
	localparam int lpRamAdrsWidth = lpUfiAdrsWidth - 1;

	// ------------------------------------------------------------------------
	// Address map
	// ------------------------------------------------------------------------
	localparam logic [7:0] lpBlockAdrs  = 8'h01;
	localparam logic [7:0] lpCsrRamWd   = 8'h00;
	localparam logic [7:0] lpCsrRamAdrs = 8'h04;
	localparam logic [7:0] lpCsrRamPush = 8'h08;
	localparam logic [7:0] lpCsrStatus  = 8'h0C;

	// FIFO sizing
	localparam int lpMfcDepth    = 16;
	localparam int lpMfcPtrWidth = $clog2(lpMfcDepth);
	localparam int lpMfcCntWidth = lpMfcPtrWidth + 1;

	// ------------------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [lpRamAdrsWidth-1:0] ramAdrs;
		logic [lpUfiDqWidth-1:0]   ramWd;
	} tMfcEntry;

	typedef struct packed {
		logic [lpGpioWidth-1:0] msb;
		logic [lpGpioWidth-1:0] lsb;
		logic                   dataEn;
		logic                   adrsEn;
	} tGpioWrite;

	typedef struct packed {
		logic [lpUsiBusWidth-1:0] wd;
		logic [lpUsiBusWidth-1:0] adrs;
	} tUsiSlave;

endpackage

// File: source/UsiMasterBridge.sv
/* GPIO to USI master bridge: write data register,
   one-cycle address strobe and read-word split */
`timescale 1ns/1ps

module UsiMasterBridge
	import McbPkg::*;
(
	input  logic                     iSCLK,
	input  logic                     iSRST,
	input  tGpioWrite                iGpioWrite,
	input  logic [lpUsiBusWidth-1:0] iMUsiRd,
	output logic [lpUsiBusWidth-1:0] oMUsiWd,
	output logic [lpUsiBusWidth-1:0] oMUsiAdrs,
	output logic [lpGpioWidth-1:0]   oGpioRdMsb,
	output logic [lpGpioWidth-1:0]   oGpioRdLsb
);

	logic [lpUsiBusWidth-1:0] wGpioWord;

	assign wGpioWord = {iGpioWrite.msb, iGpioWrite.lsb};

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oMUsiWd   <= '0;
			oMUsiAdrs <= '0;
		end
		else
		begin
			// Write data holds until the next data enable
			if (iGpioWrite.dataEn)
				oMUsiWd <= wGpioWord;
			// Address is a single-cycle strobe, zero otherwise
			oMUsiAdrs <= iGpioWrite.adrsEn ? wGpioWord : '0;
		end
	end

	// Read word back to the GPIO halves
	assign oGpioRdMsb = iMUsiRd[lpUsiBusWidth-1:lpGpioWidth];
	assign oGpioRdLsb = iMUsiRd[lpGpioWidth-1:0];

endmodule

// File: source/SyncFifoController.sv
/* Synchronous FIFO with occupancy counter, full/empty flags
   and registered read data with read-valid */
`timescale 1ns/1ps

module SyncFifoController
	import McbPkg::*;
(
	input  logic     iSCLK,
	input  logic     iSRST,
	input  tMfcEntry iWd,
	input  logic     iWe,
	input  logic     iRe,
	output tMfcEntry oRd,
	output logic     oRvd,
	output logic     oFull,
	output logic     oEmp
);

	tMfcEntry                 rMem [lpMfcDepth];
	logic [lpMfcPtrWidth-1:0] rWrPtr;
	logic [lpMfcPtrWidth-1:0] rRdPtr;
	logic [lpMfcCntWidth-1:0] rCount;
	logic                     wWrite;
	logic                     wRead;

	// Flags straight from the counter
	assign oFull = (rCount == lpMfcCntWidth'(lpMfcDepth));
	assign oEmp  = (rCount == '0);

	// Requests that hit full or empty are dropped
	assign wWrite = iWe && !oFull;
	assign wRead  = iRe && !oEmp;

	// ------------------------------------------------------------------------
	// Storage and read port
	// ------------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (wWrite)
			rMem[rWrPtr] <= iWd;
		if (wRead)
			oRd <= rMem[rRdPtr];
	end

	// ------------------------------------------------------------------------
	// Pointers and occupancy
	// ------------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rWrPtr <= '0;
			rRdPtr <= '0;
			rCount <= '0;
			oRvd   <= 1'b0;
		end
		else
		begin
			if (wWrite)
				rWrPtr <= rWrPtr + 1'b1;
			if (wRead)
				rRdPtr <= rRdPtr + 1'b1;
			// Simultaneous push and pop leave the count alone
			case ({wWrite, wRead})
				2'b10:   rCount <= rCount + 1'b1;
				2'b01:   rCount <= rCount - 1'b1;
				default: rCount <= rCount;
			endcase
			oRvd <= wRead;
		end
	end

endmodule

// File: source/MicroControllerCsr.sv
/* USI slave CSR bank with RAM data/address registers,
   push strobe generation and readback */
`timescale 1ns/1ps

module MicroControllerCsr
	import McbPkg::*;
(
	input  logic                     iSCLK,
	input  logic                     iSRST,
	input  tUsiSlave                 iSUsiAccess,
	input  logic                     iRamFull,
	input  logic                     iRamEmp,
	output logic [lpUsiBusWidth-1:0] oSUsiRd,
	output tMfcEntry                 oRamEntry,
	output logic                     oRamEn
);

	logic                      wAccess;
	logic [7:0]                wOffset;
	logic [lpUsiBusWidth-1:0]  wRdSel;
	logic [lpUfiDqWidth-1:0]   rRamWd;
	logic [lpRamAdrsWidth-1:0] rRamAdrs;
	logic                      rRamEn;

	// ------------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------------
	assign wOffset = iSUsiAccess.adrs[7:0];

	// Idle bus is all-zero address
	assign wAccess = (iSUsiAccess.adrs != '0) &&
		(iSUsiAccess.adrs[lpUsiBusWidth-1 -: 8] == lpBlockAdrs);

	// ------------------------------------------------------------------------
	// RAM request registers
	// ------------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rRamWd   <= '0;
			rRamAdrs <= '0;
		end
		else if (wAccess)
		begin
			if (wOffset == lpCsrRamWd)
				rRamWd <= iSUsiAccess.wd[lpUfiDqWidth-1:0];
			if (wOffset == lpCsrRamAdrs)
				rRamAdrs <= iSUsiAccess.wd[lpRamAdrsWidth-1:0];
		end
	end

	// Push strobe, one cycle after the push access
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rRamEn <= 1'b0;
		else
			rRamEn <= wAccess && (wOffset == lpCsrRamPush) && iSUsiAccess.wd[0];
	end

	assign oRamEn    = rRamEn;
	assign oRamEntry = '{ramAdrs: rRamAdrs, ramWd: rRamWd};

	// ------------------------------------------------------------------------
	// Readback
	// ------------------------------------------------------------------------
	// Values as they stand before this access
	always_comb
	begin
		case (wOffset)
			lpCsrRamWd:   wRdSel = lpUsiBusWidth'(rRamWd);
			lpCsrRamAdrs: wRdSel = lpUsiBusWidth'(rRamAdrs);
			lpCsrStatus:  wRdSel = lpUsiBusWidth'({iRamFull, iRamEmp});
			// Push register and unmapped offsets
			default:      wRdSel = '0;
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiRd <= '0;
		else if (wAccess)
			oSUsiRd <= wRdSel;
	end

endmodule

// File: source/MicroControllerBlock.sv
/* Management block top: CSR bank, RAM-write FIFO and
   GPIO to USI bridge, with FIFO drain onto UFI */
`timescale 1ns/1ps

module MicroControllerBlock
	import McbPkg::*;
(
	input  logic                      iSCLK,
	input  logic                      iSRST,
	input  tGpioWrite                 iGpioWrite,
	input  logic [lpUsiBusWidth-1:0]  iMUsiRd,
	input  tUsiSlave                  iSUsiAccess,
	input  logic                      iMUfiRdy,
	output logic [lpGpioWidth-1:0]    oGpioRdMsb,
	output logic [lpGpioWidth-1:0]    oGpioRdLsb,
	output logic [lpUsiBusWidth-1:0]  oMUsiWd,
	output logic [lpUsiBusWidth-1:0]  oMUsiAdrs,
	output logic [lpUsiBusWidth-1:0]  oSUsiRd,
	output logic [lpUfiDqWidth-1:0]   oMUfiWd,
	output logic [lpUfiAdrsWidth-1:0] oMUfiAdrs
);

	tMfcEntry wRamEntry;
	tMfcEntry wFifoRd;
	logic     wRamEn;
	logic     wFifoRvd;
	logic     wFull;
	logic     wEmp;
	logic     wPop;

	// ------------------------------------------------------------------------
	// CSR bank
	// ------------------------------------------------------------------------
	MicroControllerCsr MicroControllerCsr_inst (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.iSUsiAccess (iSUsiAccess),
		.iRamFull    (wFull),
		.iRamEmp     (wEmp),
		.oSUsiRd     (oSUsiRd),
		.oRamEntry   (wRamEntry),
		.oRamEn      (wRamEn)
	);

	// ------------------------------------------------------------------------
	// RAM-write FIFO and UFI drain
	// ------------------------------------------------------------------------
	// Pop whenever UFI is ready and something is queued
	assign wPop = iMUfiRdy && !wEmp;

	SyncFifoController SyncFifoController_inst (
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.iWd   (wRamEntry),
		.iWe   (wRamEn),
		.iRe   (wPop),
		.oRd   (wFifoRd),
		.oRvd  (wFifoRvd),
		.oFull (wFull),
		.oEmp  (wEmp)
	);

	assign oMUfiWd   = wFifoRd.ramWd;
	assign oMUfiAdrs = {wFifoRvd, wFifoRd.ramAdrs};

	// ------------------------------------------------------------------------
	// GPIO to USI master
	// ------------------------------------------------------------------------
	UsiMasterBridge UsiMasterBridge_inst (
		.iSCLK      (iSCLK),
		.iSRST      (iSRST),
		.iGpioWrite (iGpioWrite),
		.iMUsiRd    (iMUsiRd),
		.oMUsiWd    (oMUsiWd),
		.oMUsiAdrs  (oMUsiAdrs),
		.oGpioRdMsb (oGpioRdMsb),
		.oGpioRdLsb (oGpioRdLsb)
	);

endmodule

// File: test/McbModel.svh
/* Reference model: expected FIFO queue, CSR registers,
   bridge outputs and coverage counters */
`ifndef MCB_MODEL_SVH
`define MCB_MODEL_SVH

// Expected FIFO contents, oldest entry first
tMfcEntry                  mQueue [$];
logic [lpUsiBusWidth-1:0]  mUsiWd;
logic [lpUsiBusWidth-1:0]  mUsiAdrs;
logic [lpUsiBusWidth-1:0]  mSUsiRd;
logic [lpUfiDqWidth-1:0]   mRamWd;
logic [lpRamAdrsWidth-1:0] mRamAdrs;
logic                      mRamEn;
tMfcEntry                  mUfiEntry;
logic                      mUfiRvd;

// Coverage counters
int                        pushCount;
int                        dropCount;
// Status readback taken while the FIFO was full
logic                      sawFull;

function automatic void modelReset();
	mQueue.delete();
	mUsiWd    = '0;
	mUsiAdrs  = '0;
	mSUsiRd   = '0;
	mRamWd    = '0;
	mRamAdrs  = '0;
	mRamEn    = 1'b0;
	mUfiEntry = '0;
	mUfiRvd   = 1'b0;
	pushCount = 0;
	dropCount = 0;
	sawFull   = 1'b0;
endfunction

// One clock edge of the block with the inputs of this cycle
function automatic void modelStep(input tGpioWrite gw, input tUsiSlave acc, input logic rdy);
	logic                     full;
	logic                     empty;
	logic                     access;
	logic [7:0]               offset;
	logic [lpUsiBusWidth-1:0] rdSel;
	tMfcEntry                 entry;
	full  = (mQueue.size() == lpMfcDepth);
	empty = (mQueue.size() == 0);

	// FIFO drain, then the strobe registered on the previous edge
	mUfiRvd = 1'b0;
	if (rdy && !empty)
	begin
		mUfiEntry = mQueue.pop_front();
		mUfiRvd   = 1'b1;
	end
	if (mRamEn)
	begin
		if (!full)
		begin
			entry.ramAdrs = mRamAdrs;
			entry.ramWd   = mRamWd;
			mQueue.push_back(entry);
			pushCount++;
		end
		else
			dropCount++;
	end

	// CSR slave, readback shows the value before the access
	access = (acc.adrs != '0) && (acc.adrs[31:24] == lpBlockAdrs);
	offset = acc.adrs[7:0];
	if (access)
	begin
		if (offset == lpCsrRamWd)
			rdSel = lpUsiBusWidth'(mRamWd);
		else if (offset == lpCsrRamAdrs)
			rdSel = lpUsiBusWidth'(mRamAdrs);
		else if (offset == lpCsrStatus)
		begin
			rdSel = {30'b0, full, empty};
			if (full)
				sawFull = 1'b1;
		end
		else
			rdSel = '0;
		mSUsiRd = rdSel;
		if (offset == lpCsrRamWd)
			mRamWd = acc.wd[lpUfiDqWidth-1:0];
		if (offset == lpCsrRamAdrs)
			mRamAdrs = acc.wd[lpRamAdrsWidth-1:0];
	end
	mRamEn = access && (offset == lpCsrRamPush) && acc.wd[0];

	// GPIO bridge
	if (gw.dataEn)
		mUsiWd = {gw.msb, gw.lsb};
	mUsiAdrs = gw.adrsEn ? {gw.msb, gw.lsb} : '0;
endfunction

`endif

// File: test/McbTb.sv
/* Testbench for the management block: random LFSR stimulus,
   reference model checks and cycle timeout */
`timescale 1ns/1ps

module McbTb
	import McbPkg::*;
();

	localparam logic [15:0] lpSeed        = 16'd51009;
	localparam int          lpResetCycles = 16;
	localparam int          lpRandCycles  = 1500;
	// Worst drain is a full FIFO plus the pipeline
	localparam int          lpDrainCycles = 64;
	localparam int          lpCycleLimit  = lpResetCycles + lpRandCycles + lpDrainCycles + 420;
	// Length of the ready-high and ready-low windows
	localparam int          lpRdyWindow   = 250;

	logic                      iSCLK;
	logic                      iSRST;
	tGpioWrite                 iGpioWrite;
	logic [lpUsiBusWidth-1:0]  iMUsiRd;
	tUsiSlave                  iSUsiAccess;
	logic                      iMUfiRdy;
	logic [lpGpioWidth-1:0]    oGpioRdMsb;
	logic [lpGpioWidth-1:0]    oGpioRdLsb;
	logic [lpUsiBusWidth-1:0]  oMUsiWd;
	logic [lpUsiBusWidth-1:0]  oMUsiAdrs;
	logic [lpUsiBusWidth-1:0]  oSUsiRd;
	logic [lpUfiDqWidth-1:0]   oMUfiWd;
	logic [lpUfiAdrsWidth-1:0] oMUfiAdrs;

	logic [15:0]               lfsrState;
	int                        cycleCount;

	`include "McbModel.svh"

	MicroControllerBlock MicroControllerBlock_inst (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.iGpioWrite  (iGpioWrite),
		.iMUsiRd     (iMUsiRd),
		.iSUsiAccess (iSUsiAccess),
		.iMUfiRdy    (iMUfiRdy),
		.oGpioRdMsb  (oGpioRdMsb),
		.oGpioRdLsb  (oGpioRdLsb),
		.oMUsiWd     (oMUsiWd),
		.oMUsiAdrs   (oMUsiAdrs),
		.oSUsiRd     (oSUsiRd),
		.oMUfiWd     (oMUfiWd),
		.oMUfiAdrs   (oMUfiAdrs)
	);

	// ------------------------------------------------------------------------
	// Clock and timeout
	// ------------------------------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #20 iSCLK = ~iSCLK;
	end

	initial
		cycleCount = 0;

	always @(posedge iSCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= lpCycleLimit)
		begin
			$display("Timeout after %0d cycles, the FIFO never drained", cycleCount);
			stopOnFailure();
		end
	end

	// ------------------------------------------------------------------------
	// Random numbers and reporting
	// ------------------------------------------------------------------------
	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic stopOnFailure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
		stopOnFailure();
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	task automatic driveCycle(input logic idle, input int cyc);
		tGpioWrite  gw;
		tUsiSlave   acc;
		logic [2:0] op;
		logic [7:0] block;
		logic [7:0] offset;
		logic       rdy;
		gw  = '0;
		acc = '0;
		op  = idle ? 3'd0 : 3'(randBits(3));
		offset = '0;
		case (op)
			3'd1:
			begin
				gw.msb    = lpGpioWidth'(randBits(lpGpioWidth));
				gw.lsb    = lpGpioWidth'(randBits(lpGpioWidth));
				gw.dataEn = 1'(randBits(1));
				gw.adrsEn = 1'(randBits(1));
			end
			3'd2:
				offset = lpCsrRamWd;
			3'd3:
				offset = lpCsrRamAdrs;
			// Push is weighted double so the FIFO fills under back-pressure
			3'd4, 3'd7:
				offset = lpCsrRamPush;
			3'd5:
				offset = randBits(1) ? lpCsrStatus : 8'(randBits(8));
			default:
				;
		endcase
		if (op >= 3'd2 && op != 3'd6)
		begin
			acc.adrs = {lpBlockAdrs, 16'(randBits(16)), offset};
			acc.wd   = randBits(32);
			if (offset == lpCsrRamPush)
				acc.wd[0] = |randBits(2);
		end
		else if (op == 3'd6)
		begin
			block = 8'(randBits(8));
			if (block == lpBlockAdrs)
				block = 8'h02;
			acc.adrs = {block, 16'(randBits(16)), 8'(randBits(8))};
			acc.wd   = randBits(32);
		end
		if (idle)
			rdy = 1'b1;
		else if (((cyc / lpRdyWindow) % 2) == 1)
			rdy = 1'b0;
		else
			rdy = 1'(randBits(1));
		iGpioWrite  <= gw;
		iSUsiAccess <= acc;
		iMUfiRdy    <= rdy;
		iMUsiRd     <= randBits(32);
	endtask

	// ------------------------------------------------------------------------
	// Checks, sampled at the falling edge
	// ------------------------------------------------------------------------
	task automatic checkOutputs();
		assert (oMUsiWd === mUsiWd)
		else reportMismatch("oMUsiWd", oMUsiWd, mUsiWd);
		assert (oMUsiAdrs === mUsiAdrs)
		else reportMismatch("oMUsiAdrs", oMUsiAdrs, mUsiAdrs);
		assert (oSUsiRd === mSUsiRd)
		else reportMismatch("oSUsiRd", oSUsiRd, mSUsiRd);
		assert (oGpioRdMsb === iMUsiRd[31:16])
		else reportMismatch("oGpioRdMsb", 32'(oGpioRdMsb), 32'(iMUsiRd[31:16]));
		assert (oGpioRdLsb === iMUsiRd[15:0])
		else reportMismatch("oGpioRdLsb", 32'(oGpioRdLsb), 32'(iMUsiRd[15:0]));
		assert (oMUfiAdrs[lpUfiAdrsWidth-1] === mUfiRvd)
		else reportMismatch("oMUfiAdrs[31]", 32'(oMUfiAdrs[lpUfiAdrsWidth-1]), 32'(mUfiRvd));
		// Data fields only mean something with the valid bit
		assert (!mUfiRvd || oMUfiAdrs[lpRamAdrsWidth-1:0] === mUfiEntry.ramAdrs)
		else reportMismatch("oMUfiAdrs", 32'(oMUfiAdrs[lpRamAdrsWidth-1:0]),
			32'(mUfiEntry.ramAdrs));
		assert (!mUfiRvd || oMUfiWd === mUfiEntry.ramWd)
		else reportMismatch("oMUfiWd", 32'(oMUfiWd), 32'(mUfiEntry.ramWd));
	endtask

	task automatic runCycle(input logic idle, input int cyc);
		@(posedge iSCLK);
		driveCycle(idle, cyc);
		@(negedge iSCLK);
		checkOutputs();
		modelStep(iGpioWrite, iSUsiAccess, iMUfiRdy);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		int cyc;
		lfsrState   = lpSeed;
		iSRST       = 1'b1;
		iGpioWrite  = '0;
		iMUsiRd     = '0;
		iSUsiAccess = '0;
		iMUfiRdy    = 1'b0;
		modelReset();
		repeat (lpResetCycles) @(posedge iSCLK);
		iSRST <= 1'b0;
		@(negedge iSCLK);
		checkOutputs();
		modelStep(iGpioWrite, iSUsiAccess, iMUfiRdy);

		for (cyc = 0; cyc < lpRandCycles; cyc++)
			runCycle(1'b0, cyc);

		// Drain with UFI ready until nothing is pending
		while ((mQueue.size() != 0) || mRamEn || mUfiRvd)
			runCycle(1'b1, 0);
		runCycle(1'b1, 0);

		assert (sawFull && (dropCount > 0))
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("Run ended without a dropped push or a full status: pushed %0d dropped %0d",
				pushCount, dropCount);
			stopOnFailure();
		end
	end

endmodule

// File: vlog.f
+incdir+test
source/McbPkg.sv
source/UsiMasterBridge.sv
source/SyncFifoController.sv
source/MicroControllerCsr.sv
source/MicroControllerBlock.sv
test/McbTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the management block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module McbTb -f vlog.f -o McbTbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/McbTbSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi

echo "Simulation exited cleanly"
exit 0
